/* include/exc_macros.svh */
`ifndef EXC_MACROS_SVH
`define EXC_MACROS_SVH

// Stages F, D, E and M that the pipeline-clear token passes through
`define EXC_TOKEN_DEPTH 4

// One-hot vector address
// Bit order {fiq, irq, dataAbort, prefetchAbort, swi, undefined, reset}
`define EXC_VECTOR_W 7

// Upper bound in cycles from a pending enabled interrupt to its assert
// Covers stalls in F and D plus squash and reissue of the token
`define EXC_INT_TIMEOUT 64

`endif

/* verilog/excPkg.sv */
package excPkg;

  // Exception causes, used by the syndrome and the priority result
  typedef enum logic [2:0] {
    none          = 3'd0,
    reset         = 3'd1,
    dataAbort     = 3'd2,
    fiq           = 3'd3,
    irq           = 3'd4,
    prefetchAbort = 3'd5,
    undefined     = 3'd6,
    swi           = 3'd7
  } excCauseE;

  // Interrupt sequencer states
  typedef enum logic [1:0] {
    idle     = 2'd0,
    inFlight = 2'd1,
    squashed = 2'd2
  } seqStateE;

  // Raw synchronous causes, valid is the OR of the five
  typedef struct packed {
    logic resetEntry;
    logic dataAbort;
    logic prefetchAbort;
    logic undefined;
    logic swi;
    logic valid;
  } syncCauseS;

  // Registered interrupt outputs of the sequencer
  typedef struct packed {
    logic fiqAssert;
    logic irqAssert;
    logic tokenD;
  } intReqS;

  // Per-stage flush, D in the MSB
  typedef struct packed {
    logic flushD;
    logic flushE;
    logic flushM;
    logic flushW;
  } flushS;

endpackage

/* verilog/syncExceptionCapture.sv */
`timescale 1ns/1ps

module syncExceptionCapture (
  input  logic              clk,
  input  logic              arstN,
  // Data abort is raised by the instruction in M
  input  logic              dataAbort,
  // These come from the instruction in E
  input  logic              prefetchAbortE,
  input  logic              undefinedE,
  input  logic              swiE,
  // Winner chosen by the priority block this cycle
  input  excPkg::excCauseE  takenCause,
  output excPkg::syncCauseS syncCause,
  output excPkg::excCauseE  syndrome
);

  logic             resetEntry;
  excPkg::excCauseE syndromeQ;

  // Set while in reset, cleared by the first edge after release
  // So it is high for exactly one cycle once arstN goes high
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      resetEntry <= 1'b1;
    end else begin
      resetEntry <= 1'b0;
    end
  end

  // Pack raw causes for the priority block
  always_comb begin
    syncCause.resetEntry    = resetEntry;
    syncCause.dataAbort     = dataAbort;
    syncCause.prefetchAbort = prefetchAbortE;
    syncCause.undefined     = undefinedE;
    syncCause.swi           = swiE;
    // Quick any-cause flag
    syncCause.valid         = resetEntry | dataAbort | prefetchAbortE
                              | undefinedE | swiE;
  end

  // Syndrome register
  // Loads the winning cause, holds through cycles with no cause
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      syndromeQ <= excPkg::none;
    end else if (takenCause != excPkg::none) begin
      syndromeQ <= takenCause;
    end
  end

  // Visible one edge after the cause wins
  assign syndrome = syndromeQ;

endmodule

/* verilog/interruptSequencer.sv */
`timescale 1ns/1ps
`include "exc_macros.svh"

module interruptSequencer (
  input  logic           clk,
  input  logic           arstN,
  // Interrupt levels and their enables
  input  logic           fiq,
  input  logic           irq,
  input  logic           fiqEnabled,
  input  logic           irqEnabled,
  // Decode stall holds the token in F and D
  input  logic           stallD,
  input  excPkg::flushS  flush,
  output excPkg::intReqS intReq
);

  excPkg::seqStateE             state;
  excPkg::seqStateE             stateNext;
  // Token positions, 0 is F, 1 is D, 2 is E, 3 is M
  logic [`EXC_TOKEN_DEPTH-1:0]  tokenQ;
  logic [`EXC_TOKEN_DEPTH-2:0]  alive;
  logic                         fiqPending;
  logic                         irqPending;
  logic                         start;
  logic                         killed;
  // Set when FIQ owns the token in flight
  logic                         ownerFiq;
  logic                         fiqAssertQ;
  logic                         irqAssertQ;

  assign fiqPending = fiq & fiqEnabled;
  assign irqPending = irq & irqEnabled;

  // New token only from idle
  assign start = (state == excPkg::idle) & (fiqPending | irqPending);

  // Fetch is redirected whenever D flushes, so F dies with D
  assign alive[0] = tokenQ[0] & ~flush.flushD;
  assign alive[1] = tokenQ[1] & ~flush.flushD;
  assign alive[2] = tokenQ[2] & ~flush.flushE;

  // Token lost before reaching M
  // A flush of M while in M is the interrupt's own flush
  assign killed = |(tokenQ[`EXC_TOKEN_DEPTH-2:0] & ~alive);

  // Next state
  always_comb begin
    stateNext = state;
    case (state)
      excPkg::idle: begin
        if (start) begin
          stateNext = excPkg::inFlight;
        end
      end
      excPkg::inFlight: begin
        if (killed) begin
          stateNext = excPkg::squashed;
        end else if (tokenQ[3]) begin
          // Token retires out of M
          stateNext = excPkg::idle;
        end
      end
      // One dead cycle, then reissue from idle if still pending
      excPkg::squashed: stateNext = excPkg::idle;
      default: stateNext = excPkg::idle;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state      <= excPkg::idle;
      tokenQ     <= '0;
      ownerFiq   <= 1'b0;
      fiqAssertQ <= 1'b0;
      irqAssertQ <= 1'b0;
    end else begin
      state <= stateNext;
      // FIQ wins over IRQ when both pending
      if (start) begin
        ownerFiq <= fiqPending;
      end
      // F holds under stall
      tokenQ[0] <= start | (stallD & alive[0]);
      // D holds under stall, otherwise takes F
      tokenQ[1] <= stallD ? alive[1] : alive[0];
      // Bubble into E while D is stalled
      tokenQ[2] <= stallD ? 1'b0 : alive[1];
      tokenQ[3] <= alive[2];
      // Asserts load with the token entering M
      // Enable is checked on the way in
      fiqAssertQ <= alive[2] & ownerFiq & fiqEnabled;
      irqAssertQ <= alive[2] & ~ownerFiq & irqEnabled;
    end
  end

  // All fields straight from flops
  assign intReq.fiqAssert = fiqAssertQ;
  assign intReq.irqAssert = irqAssertQ;
  assign intReq.tokenD    = tokenQ[1];

endmodule

/* verilog/exceptionPriority.sv */
`timescale 1ns/1ps
`include "exc_macros.svh"

module exceptionPriority (
  input  excPkg::syncCauseS         syncCause,
  input  excPkg::intReqS            intReq,
  output excPkg::flushS             flush,
  output logic [`EXC_VECTOR_W-1:0]  vectorAddress,
  output excPkg::excCauseE          takenCause
);

  // Flush patterns, D E M W
  localparam excPkg::flushS FlushAll  = 4'b1111;
  localparam excPkg::flushS FlushInt  = 4'b1010;
  localparam excPkg::flushS FlushDem  = 4'b1110;
  localparam excPkg::flushS FlushDOnly = 4'b1000;

  // Vector bit positions
  localparam int VecReset         = 0;
  localparam int VecUndefined     = 1;
  localparam int VecSwi           = 2;
  localparam int VecPrefetchAbort = 3;
  localparam int VecDataAbort     = 4;
  localparam int VecIrq           = 5;
  localparam int VecFiq           = 6;

  // Highest cause wins, anything lower in the same cycle is dropped
  always_comb begin
    flush         = '0;
    vectorAddress = '0;
    takenCause    = excPkg::none;
    if (syncCause.resetEntry) begin
      flush                   = FlushAll;
      vectorAddress[VecReset] = 1'b1;
      takenCause              = excPkg::reset;
    end else if (syncCause.dataAbort) begin
      flush                       = FlushAll;
      vectorAddress[VecDataAbort] = 1'b1;
      takenCause                  = excPkg::dataAbort;
    end else if (intReq.fiqAssert) begin
      // Older instructions already done, clear D and M
      flush                 = FlushInt;
      vectorAddress[VecFiq] = 1'b1;
      takenCause            = excPkg::fiq;
    end else if (intReq.irqAssert) begin
      flush                 = FlushInt;
      vectorAddress[VecIrq] = 1'b1;
      takenCause            = excPkg::irq;
    end else if (syncCause.valid) begin
      // Only E-stage causes can be left here
      if (syncCause.prefetchAbort) begin
        flush                           = FlushDem;
        vectorAddress[VecPrefetchAbort] = 1'b1;
        takenCause                      = excPkg::prefetchAbort;
      end else if (syncCause.undefined) begin
        flush                       = FlushDem;
        vectorAddress[VecUndefined] = 1'b1;
        takenCause                  = excPkg::undefined;
      end else begin
        // SWI only kills the instruction behind it
        flush                 = FlushDOnly;
        vectorAddress[VecSwi] = 1'b1;
        takenCause            = excPkg::swi;
      end
    end
  end

endmodule

/* verilog/exceptionUnit.sv */
`timescale 1ns/1ps
`include "exc_macros.svh"

module exceptionUnit (
  input  logic                      clk,
  input  logic                      arstN,
  input  logic                      dataAbort,
  input  logic                      prefetchAbortE,
  input  logic                      undefinedE,
  input  logic                      swiE,
  input  logic                      fiq,
  input  logic                      irq,
  input  logic                      fiqEnabled,
  input  logic                      irqEnabled,
  input  logic                      stallD,
  output excPkg::flushS             flush,
  output logic [`EXC_VECTOR_W-1:0]  vectorAddress,
  output excPkg::excCauseE          syndrome,
  output logic                      fiqAssert,
  output logic                      irqAssert,
  output logic                      pipelineClearD
);

  excPkg::syncCauseS syncCause;
  excPkg::intReqS    intReq;
  excPkg::excCauseE  takenCause;

  // Synchronous causes, reset entry and syndrome
  syncExceptionCapture u_syncExceptionCapture (
    .clk            (clk),
    .arstN          (arstN),
    .dataAbort      (dataAbort),
    .prefetchAbortE (prefetchAbortE),
    .undefinedE     (undefinedE),
    .swiE           (swiE),
    .takenCause     (takenCause),
    .syncCause      (syncCause),
    .syndrome       (syndrome)
  );

  // FIQ/IRQ token sequencing, sees the flush it helped choose
  interruptSequencer u_interruptSequencer (
    .clk        (clk),
    .arstN      (arstN),
    .fiq        (fiq),
    .irq        (irq),
    .fiqEnabled (fiqEnabled),
    .irqEnabled (irqEnabled),
    .stallD     (stallD),
    .flush      (flush),
    .intReq     (intReq)
  );

  exceptionPriority u_exceptionPriority (
    .syncCause     (syncCause),
    .intReq        (intReq),
    .flush         (flush),
    .vectorAddress (vectorAddress),
    .takenCause    (takenCause)
  );

  // Interrupt fields out to the core
  assign fiqAssert      = intReq.fiqAssert;
  assign irqAssert      = intReq.irqAssert;
  assign pipelineClearD = intReq.tokenD;

endmodule

/* sim/exceptionUnit_properties.sv */
`timescale 1ns/1ps
`include "exc_macros.svh"

module exceptionUnitProps (
  input logic                     clk,
  input logic                     arstN,
  input logic                     dataAbort,
  input logic                     prefetchAbortE,
  input logic                     undefinedE,
  input logic                     swiE,
  input logic                     fiq,
  input logic                     irq,
  input logic                     fiqEnabled,
  input logic                     irqEnabled,
  input logic                     stallD,
  input excPkg::flushS            flush,
  input logic [`EXC_VECTOR_W-1:0] vectorAddress,
  input excPkg::excCauseE         syndrome,
  input logic                     fiqAssert,
  input logic                     irqAssert,
  input logic                     pipelineClearD
);

  // Read by the testbench at the end of the run
  int unsigned failCount = 0;

  logic                     firstCycle;
  logic [3:0]               expFlush;
  logic [`EXC_VECTOR_W-1:0] expVector;
  excPkg::excCauseE         expCause;
  excPkg::excCauseE         expSyndrome;
  logic [3:0]               quietCount;

  // High only in the first cycle after reset release
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      firstCycle <= 1'b1;
    end else begin
      firstCycle <= 1'b0;
    end
  end

  // Priority table with the highest row first
  // Vector bits {fiq, irq, dataAbort, prefetchAbort, swi, undefined, reset}
  always_comb begin
    expFlush  = 4'b0000;
    expVector = '0;
    expCause  = excPkg::none;
    if (firstCycle) begin
      expFlush     = 4'b1111;
      expVector[0] = 1'b1;
      expCause     = excPkg::reset;
    end else if (dataAbort) begin
      expFlush     = 4'b1111;
      expVector[4] = 1'b1;
      expCause     = excPkg::dataAbort;
    end else if (fiqAssert) begin
      expFlush     = 4'b1010;
      expVector[6] = 1'b1;
      expCause     = excPkg::fiq;
    end else if (irqAssert) begin
      expFlush     = 4'b1010;
      expVector[5] = 1'b1;
      expCause     = excPkg::irq;
    end else if (prefetchAbortE) begin
      expFlush     = 4'b1110;
      expVector[3] = 1'b1;
      expCause     = excPkg::prefetchAbort;
    end else if (undefinedE) begin
      expFlush     = 4'b1110;
      expVector[1] = 1'b1;
      expCause     = excPkg::undefined;
    end else if (swiE) begin
      expFlush     = 4'b1000;
      expVector[2] = 1'b1;
      expCause     = excPkg::swi;
    end
  end

  // Last winner kept through quiet cycles
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      expSyndrome <= excPkg::none;
    end else if (expCause != excPkg::none) begin
      expSyndrome <= expCause;
    end
  end

  // Quiet cycles with no request, stall, token in D or assert
  // Enough of them means the sequencer sits in idle
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      quietCount <= '0;
    end else if ((fiq && fiqEnabled) || (irq && irqEnabled) || stallD || pipelineClearD
                 || fiqAssert || irqAssert) begin
      quietCount <= '0;
    end else if (quietCount != 4'hf) begin
      quietCount <= quietCount + 4'd1;
    end
  end

  tableRow: assert property (@(posedge clk) disable iff (!arstN)
      flush == expFlush && vectorAddress == expVector)
    else begin
      failCount++;
      $error("Error at %0t: flush/vectorAddress expected %b/%b got %b/%b",
             $time, $sampled(expFlush), $sampled(expVector),
             $sampled(flush), $sampled(vectorAddress));
    end

  vectorOneHot: assert property (@(posedge clk) disable iff (!arstN)
      $onehot0(vectorAddress))
    else begin
      failCount++;
      $error("vectorAddress is neither one-hot nor zero at %0t", $time);
    end

  // Reset vector only in the entry cycle
  resetBitOnce: assert property (@(posedge clk) disable iff (!arstN)
      !firstCycle |-> !vectorAddress[0])
    else begin
      failCount++;
      $error("Reset vector bit set after the reset entry cycle at %0t", $time);
    end

  syndromeHold: assert property (@(posedge clk) disable iff (!arstN)
      syndrome == expSyndrome)
    else begin
      failCount++;
      $error("Error at %0t: syndrome expected %0d got %0d",
             $time, $sampled(expSyndrome), $sampled(syndrome));
    end

  assertExclusive: assert property (@(posedge clk) disable iff (!arstN)
      !(fiqAssert && irqAssert))
    else begin
      failCount++;
      $error("FIQ and IRQ asserted in the same cycle at %0t", $time);
    end

  // From an idle start the FIQ token reaches M on the fourth edge
  fiqLatency: assert property (@(posedge clk) disable iff (!arstN)
      $past(quietCount >= `EXC_TOKEN_DEPTH && fiq && fiqEnabled, 4)
      && $past(!stallD && !flush.flushD, 3) && $past(!stallD && !flush.flushD, 2)
      && $past(!flush.flushE && fiqEnabled) |-> fiqAssert)
    else begin
      failCount++;
      $error("FIQ not asserted four cycles after an idle start at %0t", $time);
    end

  // An assert always follows the token two cycles after D
  tokenFromD: assert property (@(posedge clk) disable iff (!arstN)
      (fiqAssert || irqAssert) |-> $past(pipelineClearD, 2))
    else begin
      failCount++;
      $error("Interrupt asserted without a token in D two cycles before at %0t", $time);
    end

  // Unstalled, unflushed token in D reaches M
  tokenArrives: assert property (@(posedge clk) disable iff (!arstN)
      $past(pipelineClearD && !stallD && !flush.flushD, 2)
      && $past(!flush.flushE && fiqEnabled && irqEnabled)
      |-> (fiqAssert || irqAssert))
    else begin
      failCount++;
      $error("Token left D unhindered but no interrupt asserted at %0t", $time);
    end

  // Token started while FIQ was pending must belong to FIQ
  fiqOverIrq: assert property (@(posedge clk) disable iff (!arstN)
      irqAssert && $past(pipelineClearD, 2) && !$past(pipelineClearD, 3)
      && !$past(stallD, 4) |-> !$past(fiq && fiqEnabled, 4))
    else begin
      failCount++;
      $error("IRQ taken although FIQ was pending at token start, at %0t", $time);
    end

  disabledNever: assert property (@(posedge clk) disable iff (!arstN)
      (!fiqAssert || $past(fiqEnabled)) && (!irqAssert || $past(irqEnabled)))
    else begin
      failCount++;
      $error("Disabled interrupt asserted at %0t", $time);
    end

  abortInD: assert property (@(posedge clk) disable iff (!arstN)
      $past(pipelineClearD && dataAbort) |-> !pipelineClearD)
    else begin
      failCount++;
      $error("Token survived a data abort in D at %0t", $time);
    end

  // Token sits in E in the cycle of the abort
  abortInE: assert property (@(posedge clk) disable iff (!arstN)
      $past(pipelineClearD && !stallD && !flush.flushD, 2) && $past(dataAbort)
      |-> !(fiqAssert || irqAssert))
    else begin
      failCount++;
      $error("Interrupt asserted after a data abort hit the token in E at %0t", $time);
    end

endmodule

bind exceptionUnit exceptionUnitProps u_exceptionUnitProps (
  .clk            (clk),
  .arstN          (arstN),
  .dataAbort      (dataAbort),
  .prefetchAbortE (prefetchAbortE),
  .undefinedE     (undefinedE),
  .swiE           (swiE),
  .fiq            (fiq),
  .irq            (irq),
  .fiqEnabled     (fiqEnabled),
  .irqEnabled     (irqEnabled),
  .stallD         (stallD),
  .flush          (flush),
  .vectorAddress  (vectorAddress),
  .syndrome       (syndrome),
  .fiqAssert      (fiqAssert),
  .irqAssert      (irqAssert),
  .pipelineClearD (pipelineClearD)
);

/* sim/exceptionUnitTb.sv */
`timescale 1ns/1ps
`include "exc_macros.svh"

module exceptionUnitTb;

  logic                     clk;
  logic                     arstN;
  logic                     dataAbort;
  logic                     prefetchAbortE;
  logic                     undefinedE;
  logic                     swiE;
  logic                     fiq;
  logic                     irq;
  logic                     fiqEnabled;
  logic                     irqEnabled;
  logic                     stallD;
  excPkg::flushS            flush;
  logic [`EXC_VECTOR_W-1:0] vectorAddress;
  excPkg::excCauseE         syndrome;
  logic                     fiqAssert;
  logic                     irqAssert;
  logic                     pipelineClearD;

  integer      seed;
  int          timeouts;
  int          fiqAge;
  int          irqAge;
  int          i;
  logic [31:0] r;
  logic [31:0] rEn;

  exceptionUnit u_exceptionUnit (
    .clk            (clk),
    .arstN          (arstN),
    .dataAbort      (dataAbort),
    .prefetchAbortE (prefetchAbortE),
    .undefinedE     (undefinedE),
    .swiE           (swiE),
    .fiq            (fiq),
    .irq            (irq),
    .fiqEnabled     (fiqEnabled),
    .irqEnabled     (irqEnabled),
    .stallD         (stallD),
    .flush          (flush),
    .vectorAddress  (vectorAddress),
    .syndrome       (syndrome),
    .fiqAssert      (fiqAssert),
    .irqAssert      (irqAssert),
    .pipelineClearD (pipelineClearD)
  );

  // 40 ns clock
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Inputs move 2 ns after the edge
  task automatic stepCycle();
    @(posedge clk);
    #2;
  endtask

  task automatic clearCauses();
    dataAbort      = 1'b0;
    prefetchAbortE = 1'b0;
    undefinedE     = 1'b0;
    swiE           = 1'b0;
  endtask

  // Polls once per cycle
  // Which picks fiqAssert (0), irqAssert (1) or else pipelineClearD
  task automatic waitFor(input int which, input string what);
    int n;
    bit seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < `EXC_INT_TIMEOUT) begin
      stepCycle();
      n++;
      case (which)
        0: seen = fiqAssert;
        1: seen = irqAssert;
        default: seen = pipelineClearD;
      endcase
    end
    if (!seen) begin
      timeouts++;
      $display("Timeout at %0t: no %s within %0d cycles", $time, what, `EXC_INT_TIMEOUT);
    end
  endtask

  initial begin
    seed     = 32'h6edf8216;
    timeouts = 0;
    arstN    = 1'b0;
    clearCauses();
    fiq        = 1'b0;
    irq        = 1'b0;
    fiqEnabled = 1'b0;
    irqEnabled = 1'b0;
    stallD     = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    arstN = 1'b1;
    // Reset entry, then a few quiet cycles
    repeat (3) stepCycle();

    // Every mix of synchronous causes with a quiet cycle after each
    for (i = 0; i < 16; i++) begin
      {dataAbort, prefetchAbortE, undefinedE, swiE} = i[3:0];
      stepCycle();
      clearCauses();
      stepCycle();
    end

    // Lone FIQ, then FIQ and IRQ together
    fiqEnabled = 1'b1;
    irqEnabled = 1'b1;
    fiq        = 1'b1;
    waitFor(0, "FIQ assert");
    fiq = 1'b0;
    repeat (6) stepCycle();
    fiq = 1'b1;
    irq = 1'b1;
    waitFor(0, "FIQ assert with IRQ pending");
    fiq = 1'b0;
    waitFor(1, "IRQ assert");
    irq = 1'b0;
    repeat (6) stepCycle();

    // Both levels high with both enables off
    fiqEnabled = 1'b0;
    irqEnabled = 1'b0;
    fiq        = 1'b1;
    irq        = 1'b1;
    repeat (20) stepCycle();
    fiq        = 1'b0;
    irq        = 1'b0;
    fiqEnabled = 1'b1;
    irqEnabled = 1'b1;
    repeat (2) stepCycle();

    // Data abort hits the token in D
    irq = 1'b1;
    waitFor(2, "pipeline clear in D");
    dataAbort = 1'b1;
    stepCycle();
    dataAbort = 1'b0;
    waitFor(1, "IRQ assert after reissue");
    // Then in E one cycle after D
    waitFor(2, "pipeline clear in D");
    stepCycle();
    dataAbort = 1'b1;
    stepCycle();
    dataAbort = 1'b0;
    waitFor(1, "IRQ assert after reissue");
    irq = 1'b0;
    repeat (6) stepCycle();

    // Random causes, stalls and levels
    // Each age counts cycles of its request pending without its assert
    // IRQ is not aged while FIQ is pending and wins
    fiqAge = 0;
    irqAge = 0;
    for (i = 0; i < 300; i++) begin
      @(posedge clk);
      #1;
      if (fiqAssert || !(fiq && fiqEnabled)) begin
        fiqAge = 0;
      end else begin
        fiqAge++;
      end
      if (irqAssert || !(irq && irqEnabled) || (fiq && fiqEnabled)) begin
        irqAge = 0;
      end else begin
        irqAge++;
      end
      if (fiqAge > `EXC_INT_TIMEOUT || irqAge > `EXC_INT_TIMEOUT) begin
        timeouts++;
        $display("Timeout at %0t: pending interrupt not asserted in time", $time);
        fiqAge = 0;
        irqAge = 0;
      end
      #1;
      r              = $random(seed);
      rEn            = $random(seed);
      dataAbort      = (r[4:0] == 5'd0);
      prefetchAbortE = (r[9:5] == 5'd0);
      undefinedE     = (r[14:10] == 5'd0);
      swiE           = (r[19:15] == 5'd0);
      stallD         = (r[21:20] == 2'b00);
      // Levels and enables change rarely so requests stay pending for long
      if (r[27:22] == 6'd0) begin
        fiq = ~fiq;
      end
      if (rEn[17:12] == 6'd0) begin
        irq = ~irq;
      end
      if (rEn[5:0] == 6'd0) begin
        fiqEnabled = ~fiqEnabled;
      end
      if (rEn[11:6] == 6'd0) begin
        irqEnabled = ~irqEnabled;
      end
    end

    clearCauses();
    fiq    = 1'b0;
    irq    = 1'b0;
    stallD = 1'b0;
    repeat (8) stepCycle();

    $display("Assertion failures: %0d, timeouts: %0d",
             u_exceptionUnit.u_exceptionUnitProps.failCount, timeouts);
    if (u_exceptionUnit.u_exceptionUnitProps.failCount == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+include
verilog/excPkg.sv
verilog/syncExceptionCapture.sv
verilog/interruptSequencer.sv
verilog/exceptionPriority.sv
verilog/exceptionUnit.sv
sim/exceptionUnit_properties.sv
sim/exceptionUnitTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := exceptionUnitTb
FILELIST  := build.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert
RUNFLAGS  := +verilator+error+limit+1000
LOG       := sim.log
PASS_MSG  := >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	grep -qF -- "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
